// File: test/spi_vectors.txt
# name op addr wstrb wdata exp_resp exp_data (all hex)
# op W write, R read, X transfer, B transfer with a second TXDATA write while busy
ctrl_rst      R 20010000 0 00000000 0 00000003
ctrl_wr       W 20010000 f 000000a5 0 00000000
ctrl_rd       R 20010000 0 00000000 0 000000a5
ctrl_div      W 20010000 1 00000002 0 00000000
ctrl_rd2      R 20010000 0 00000000 0 00000002
xfer_byte     X 20010008 1 123456c3 0 000000c3
stat_clr      R 20010004 0 00000000 0 00000000
xfer_half     X 20010008 3 9abc5a3c 0 00005a3c
xfer_word     X 20010008 f deadbeef 0 deadbeef
err_window    W 20020008 f 00000011 2 00000000
err_rd_window R 20010020 0 00000000 2 00000000
err_status    W 20010004 f 00000001 2 00000000
err_rxdata    W 2001000c f 00000001 2 00000000
rx_keep       R 2001000c 0 00000000 0 deadbeef
err_strb      W 20010008 2 00000077 2 00000000
tx_keep       R 20010008 0 00000000 0 deadbeef
err_offset    R 20010010 0 00000000 2 00000000
err_busy      B 20010008 1 00000081 0 00000081
tx_busy_keep  R 20010008 0 00000000 0 00000081
idle_stat     R 20010004 0 00000000 0 00000000

// File: verilog.f
+incdir+src
src/spi_pkg.sv
src/axi_spi_bridge.sv
src/spi_regs.sv
src/spi_xfer_fsm.sv
src/spi_bit_timer.sv
src/spi_shift_reg.sv
src/spi_subsys_top.sv
test/spi_props.sv
test/tb_spi_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_subsys
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_spi_subsys.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module tb_spi_subsys
   import spi_pkg::*;
();

   localparam int WAIT_LIMIT = 4000;

   logic              clk;
   logic              rstn;
   logic [31:0]       awaddr;
   logic              awvalid;
   logic              awready;
   logic [31:0]       wdata;
   logic [3:0]        wstrb;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [31:0]       araddr;
   logic              arvalid;
   logic              arready;
   logic [31:0]       rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;
   logic              sclk;
   logic              mosi;
   logic              miso;
   logic              cs_n;
   logic              irq;

   string cur_test;
   int    tests;
   int    checks;
   int    errors;
   int    test_errs;
   bit    timed_out;

   // single slave, data comes straight back
   assign miso = mosi;

   spi_subsys_top dut_i (
      .s_axi_aclk_i    (clk),
      .s_axi_aresetn_i (rstn),
      .s_axi_awaddr_i  (awaddr),
      .s_axi_awvalid_i (awvalid),
      .s_axi_awready_o (awready),
      .s_axi_wdata_i   (wdata),
      .s_axi_wstrb_i   (wstrb),
      .s_axi_wvalid_i  (wvalid),
      .s_axi_wready_o  (wready),
      .s_axi_bresp_o   (bresp),
      .s_axi_bvalid_o  (bvalid),
      .s_axi_bready_i  (bready),
      .s_axi_araddr_i  (araddr),
      .s_axi_arvalid_i (arvalid),
      .s_axi_arready_o (arready),
      .s_axi_rdata_o   (rdata),
      .s_axi_rresp_o   (rresp),
      .s_axi_rvalid_o  (rvalid),
      .s_axi_rready_i  (rready),
      .sclk_o          (sclk),
      .mosi_o          (mosi),
      .miso_i          (miso),
      .cs_n_o          (cs_n),
      .irq_o           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic timeout_error(input string what);
      $display("ERROR: test %s timed out waiting for %s", cur_test, what);
      errors++;
      test_errs++;
      timed_out = 1'b1;
   endtask

   task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act) else begin
         $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data, output logic [1:0] resp);
      int         n;
      int         stall;
      logic [1:0] first;
      if (timed_out) return;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!awready && n < WAIT_LIMIT);
      if (!awready) begin
         timeout_error("awready");
         return;
      end
      // address and data are taken in the same cycle
      expect_eq("wready with awready", 32'd1, {31'd0, wready});
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!bvalid && n < WAIT_LIMIT);
      if (!bvalid) begin
         timeout_error("bvalid");
         return;
      end
      first = bresp;
      // hold bready low for a while, the response must not move
      stall = $urandom % 6;
      repeat (stall + 1) begin
         expect_eq("bvalid held", 32'd1, {31'd0, bvalid});
         expect_eq("bresp held", {30'd0, first}, {30'd0, bresp});
         @(negedge clk);
      end
      @(posedge clk);
      bready <= 1'b1;
      @(negedge clk);
      expect_eq("bresp at accept", {30'd0, first}, {30'd0, bresp});
      @(posedge clk);
      bready <= 1'b0;
      resp = first;
   endtask

   task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int          n;
      int          stall;
      logic [31:0] first;
      if (timed_out) return;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!arready && n < WAIT_LIMIT);
      if (!arready) begin
         timeout_error("arready");
         return;
      end
      @(posedge clk);
      arvalid <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!rvalid && n < WAIT_LIMIT);
      if (!rvalid) begin
         timeout_error("rvalid");
         return;
      end
      first = rdata;
      resp  = rresp;
      stall = $urandom % 6;
      repeat (stall + 1) begin
         expect_eq("rvalid held", 32'd1, {31'd0, rvalid});
         expect_eq("rdata held", first, rdata);
         @(negedge clk);
      end
      @(posedge clk);
      rready <= 1'b1;
      @(negedge clk);
      expect_eq("rdata at accept", first, rdata);
      expect_eq("rresp at accept", {30'd0, resp}, {30'd0, rresp});
      @(posedge clk);
      rready <= 1'b0;
      data = first;
   endtask

   // wait for the done level, then STATUS and RXDATA
   task automatic finish_transfer(input logic [31:0] exp_rx);
      int          n;
      logic [31:0] data;
      logic [1:0]  resp;
      if (timed_out) return;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!irq && n < WAIT_LIMIT);
      if (!irq) begin
         timeout_error("irq_o after the transfer");
         return;
      end
      axi_read(`SPI_BASE_ADDR + 32'h04, data, resp);
      expect_eq("STATUS rresp", RESP_OKAY, {30'd0, resp});
      // done set and busy clear
      expect_eq("STATUS after transfer", 32'h2, data);
      @(negedge clk);
      expect_eq("irq_o after STATUS read", 32'd0, {31'd0, irq});
      axi_read(`SPI_BASE_ADDR + 32'h0C, data, resp);
      expect_eq("RXDATA rresp", RESP_OKAY, {30'd0, resp});
      expect_eq("RXDATA", exp_rx, data);
   endtask

   initial begin
      int          fd;
      int          code;
      string       line;
      string       name;
      string       op;
      logic [31:0] addr;
      logic [31:0] strb;
      logic [31:0] data;
      logic [31:0] exp_resp;
      logic [31:0] exp_data;
      logic [31:0] rd;
      logic [1:0]  resp;
      void'($urandom(93090));
      tests     = 0;
      checks    = 0;
      errors    = 0;
      timed_out = 1'b0;
      rstn    <= 1'b0;
      awaddr  <= '0;
      awvalid <= 1'b0;
      wdata   <= '0;
      wstrb   <= '0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      araddr  <= '0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      fd = $fopen("test/spi_vectors.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open test/spi_vectors.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            code = $sscanf(line, "%s %s %h %h %h %h %h",
                           name, op, addr, strb, data, exp_resp, exp_data);
            if (code != 7) begin
               $display("ERROR: malformed vector line: %s", line);
               errors++;
               continue;
            end
            cur_test  = name;
            test_errs = 0;
            tests++;
            repeat ($urandom % 6) @(posedge clk);
            if (op == "W") begin
               axi_write(addr, strb[3:0], data, resp);
               expect_eq("bresp", exp_resp, {30'd0, resp});
            end else if (op == "R") begin
               axi_read(addr, rd, resp);
               expect_eq("rresp", exp_resp, {30'd0, resp});
               if (exp_resp == RESP_OKAY) expect_eq("rdata", exp_data, rd);
            end else if (op == "X") begin
               axi_write(addr, strb[3:0], data, resp);
               expect_eq("TXDATA bresp", exp_resp, {30'd0, resp});
               finish_transfer(exp_data);
            end else if (op == "B") begin
               axi_write(addr, strb[3:0], data, resp);
               expect_eq("TXDATA bresp", exp_resp, {30'd0, resp});
               // second start lands while the first one is still shifting
               axi_write(addr, strb[3:0], ~data, resp);
               expect_eq("bresp while busy", RESP_SLVERR, {30'd0, resp});
               finish_transfer(exp_data);
            end else begin
               $display("ERROR: test %s has unknown op %s", name, op);
               errors++;
               test_errs++;
            end
            $display("test %-14s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "bad",
                     test_errs);
            if (timed_out) break;
         end
         $fclose(fd);
      end
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: test/spi_props.sv
`timescale 1ns/1ps

module spi_props (
   input logic        clk_i,
   input logic        rstn_i,
   input logic        cs_n_i,
   input logic        sclk_i,
   input logic        mosi_i,
   input logic        bvalid_i,
   input logic        bready_i,
   input logic [1:0]  bresp_i,
   input logic        rvalid_i,
   input logic        rready_i,
   input logic [31:0] rdata_i
);

   // outputs settle one clock after a reset edge
   reset_idle: assert property (@(posedge clk_i)
      !rstn_i |=> cs_n_i && !bvalid_i && !rvalid_i)
      else $error("cs_n not high or a valid not low after reset");

   b_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
      else $error("write response dropped or changed before bready");

   r_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
      else $error("read response dropped or changed before rready");

   sclk_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
      cs_n_i |-> !sclk_i)
      else $error("sclk high while cs_n is released");

   // mode 0 data must not move on the sampling edge
   mosi_setup: assert property (@(posedge clk_i) disable iff (!rstn_i)
      $rose(sclk_i) |-> $stable(mosi_i))
      else $error("mosi changed at an sclk rising edge");

endmodule

bind spi_subsys_top spi_props props_i (
   .clk_i    (s_axi_aclk_i),
   .rstn_i   (s_axi_aresetn_i),
   .cs_n_i   (cs_n_o),
   .sclk_i   (sclk_o),
   .mosi_i   (mosi_o),
   .bvalid_i (s_axi_bvalid_o),
   .bready_i (s_axi_bready_i),
   .bresp_i  (s_axi_bresp_o),
   .rvalid_i (s_axi_rvalid_o),
   .rready_i (s_axi_rready_i),
   .rdata_i  (s_axi_rdata_o)
);

// File: src/spi_subsys_top.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_subsys_top
   import spi_pkg::*;
(
   input  logic                s_axi_aclk_i,
   input  logic                s_axi_aresetn_i,
   input  logic [31:0]         s_axi_awaddr_i,
   input  logic                s_axi_awvalid_i,
   output logic                s_axi_awready_o,
   input  logic [`SPI_DW-1:0]  s_axi_wdata_i,
   input  logic [3:0]          s_axi_wstrb_i,
   input  logic                s_axi_wvalid_i,
   output logic                s_axi_wready_o,
   output logic [1:0]          s_axi_bresp_o,
   output logic                s_axi_bvalid_o,
   input  logic                s_axi_bready_i,
   input  logic [31:0]         s_axi_araddr_i,
   input  logic                s_axi_arvalid_i,
   output logic                s_axi_arready_o,
   output logic [`SPI_DW-1:0]  s_axi_rdata_o,
   output logic [1:0]          s_axi_rresp_o,
   output logic                s_axi_rvalid_o,
   input  logic                s_axi_rready_i,
   output logic                sclk_o,
   output logic                mosi_o,
   input  logic                miso_i,
   output logic                cs_n_o,
   output logic                irq_o
);

   logic               reg_wr;
   logic               reg_rd;
   spi_reg_e           reg_addr;
   logic [`SPI_DW-1:0] reg_wdata;
   logic [3:0]         reg_wstrb;
   logic [`SPI_DW-1:0] reg_rdata;
   logic               reg_err;
   logic               start;
   spi_size_e          size;
   logic [`SPI_DW-1:0] tx_data;
   logic [`SPI_DW-1:0] rx_data;
   logic [7:0]         div;
   logic               busy;
   logic               done;
   logic               run;
   logic               load;
   logic               rise;
   logic               fall;
   logic               last_bit;

   axi_spi_bridge bridge_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wstrb_i   (s_axi_wstrb_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bresp_o   (s_axi_bresp_o),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_rresp_o   (s_axi_rresp_o),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .reg_wr_o        (reg_wr),
      .reg_rd_o        (reg_rd),
      .reg_addr_o      (reg_addr),
      .reg_wdata_o     (reg_wdata),
      .reg_wstrb_o     (reg_wstrb),
      .reg_rdata_i     (reg_rdata),
      .reg_err_i       (reg_err)
   );

   spi_regs regs_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .reg_wr_i        (reg_wr),
      .reg_rd_i        (reg_rd),
      .reg_addr_i      (reg_addr),
      .reg_wdata_i     (reg_wdata),
      .reg_wstrb_i     (reg_wstrb),
      .reg_rdata_o     (reg_rdata),
      .reg_err_o       (reg_err),
      .start_o         (start),
      .size_o          (size),
      .tx_data_o       (tx_data),
      .div_o           (div),
      .busy_i          (busy),
      .done_i          (done),
      .rx_data_i       (rx_data),
      .irq_o           (irq_o)
   );

   spi_xfer_fsm fsm_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .start_i         (start),
      .rise_i          (rise),
      .fall_i          (fall),
      .last_bit_i      (last_bit),
      .run_o           (run),
      .load_o          (load),
      .cs_n_o          (cs_n_o),
      .busy_o          (busy),
      .done_o          (done)
   );

   spi_bit_timer timer_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .run_i           (run),
      .div_i           (div),
      .size_i          (size),
      .sclk_o          (sclk_o),
      .rise_o          (rise),
      .fall_o          (fall),
      .last_bit_o      (last_bit)
   );

   spi_shift_reg shift_i (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .load_i          (load),
      .tx_data_i       (tx_data),
      .size_i          (size),
      .rise_i          (rise),
      .fall_i          (fall),
      .mosi_o          (mosi_o),
      .miso_i          (miso_i),
      .rx_data_o       (rx_data)
   );

endmodule

// File: src/spi_shift_reg.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_shift_reg
   import spi_pkg::*;
(
   input  logic                s_axi_aclk_i,
   input  logic                s_axi_aresetn_i,
   input  logic                load_i,
   input  logic [`SPI_DW-1:0]  tx_data_i,
   input  spi_size_e           size_i,
   input  logic                rise_i,
   input  logic                fall_i,
   output logic                mosi_o,
   input  logic                miso_i,
   output logic [`SPI_DW-1:0]  rx_data_o
);

   logic [`SPI_DW-1:0] tx_q;
   logic [`SPI_DW-1:0] rx_q;
   logic [`SPI_DW-1:0] tx_aligned;

   // push the active bits up to the MSB so the top bit always drives mosi
   always_comb begin
      case (size_i)
         SZ_HALF: tx_aligned = {tx_data_i[15:0], 16'd0};
         SZ_WORD: tx_aligned = tx_data_i;
         default: tx_aligned = {tx_data_i[7:0], 24'd0};
      endcase
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         tx_q <= '0;
      end else if (load_i) begin
         tx_q <= tx_aligned;
      end else if (fall_i) begin
         tx_q <= {tx_q[`SPI_DW-2:0], 1'b0};
      end
   end

   // mode 0 samples on the rising edge
   always_ff @(posedge s_axi_aclk_i) begin
      if (load_i) begin
         rx_q <= '0;
      end else if (rise_i) begin
         rx_q <= {rx_q[`SPI_DW-2:0], miso_i};
      end
   end

   assign mosi_o = tx_q[`SPI_DW-1];

   always_comb begin
      case (size_i)
         SZ_HALF: rx_data_o = {16'd0, rx_q[15:0]};
         SZ_WORD: rx_data_o = rx_q;
         default: rx_data_o = {24'd0, rx_q[7:0]};
      endcase
   end

endmodule

// File: src/spi_bit_timer.sv
`timescale 1ns/1ps

module spi_bit_timer
   import spi_pkg::*;
(
   input  logic       s_axi_aclk_i,
   input  logic       s_axi_aresetn_i,
   input  logic       run_i,
   input  logic [7:0] div_i,
   input  spi_size_e  size_i,
   output logic       sclk_o,
   output logic       rise_o,
   output logic       fall_o,
   output logic       last_bit_o
);

   logic [7:0] cnt_q;
   logic       sclk_q;
   logic [4:0] bit_q;
   logic [4:0] bit_preset;
   logic       half_end;

   always_comb begin
      case (size_i)
         SZ_HALF: bit_preset = 5'd15;
         SZ_WORD: bit_preset = 5'd31;
         default: bit_preset = 5'd7;
      endcase
   end

   // half period is div+1 clocks
   assign half_end = run_i && (cnt_q >= div_i);
   assign rise_o   = half_end && !sclk_q;
   assign fall_o   = half_end && sclk_q;

   // idle state doubles as reset, so sclk parks low between transfers
   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i || !run_i) begin
         cnt_q  <= 8'd0;
         sclk_q <= 1'b0;
         bit_q  <= bit_preset;
      end else if (half_end) begin
         cnt_q  <= 8'd0;
         sclk_q <= !sclk_q;
         if (fall_o && bit_q != 5'd0) begin
            bit_q <= bit_q - 5'd1;
         end
      end else begin
         cnt_q <= cnt_q + 8'd1;
      end
   end

   assign sclk_o     = sclk_q;
   assign last_bit_o = (bit_q == 5'd0);

endmodule

// File: src/spi_xfer_fsm.sv
`timescale 1ns/1ps

module spi_xfer_fsm (
   input  logic s_axi_aclk_i,
   input  logic s_axi_aresetn_i,
   input  logic start_i,
   input  logic rise_i,
   input  logic fall_i,
   input  logic last_bit_i,
   output logic run_o,
   output logic load_o,
   output logic cs_n_o,
   output logic busy_o,
   output logic done_o
);

   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      SETUP = 2'd1,
      SHIFT = 2'd2,
      HOLD  = 2'd3
   } state_e;

   state_e state_q;
   state_e state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (start_i) state_d = SETUP;
         // one cycle to load the shift register with cs_n already low
         SETUP:   state_d = SHIFT;
         SHIFT:   if (rise_i && last_bit_i) state_d = HOLD;
         // trailing half period, sclk returns low as cs_n releases
         HOLD:    if (fall_i) state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign run_o  = (state_q == SHIFT) || (state_q == HOLD);
   assign load_o = (state_q == SETUP);
   assign cs_n_o = (state_q == IDLE);
   assign busy_o = (state_q != IDLE);
   assign done_o = (state_q == HOLD) && fall_i;

endmodule

// File: src/spi_regs.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_regs
   import spi_pkg::*;
(
   input  logic                s_axi_aclk_i,
   input  logic                s_axi_aresetn_i,
   input  logic                reg_wr_i,
   input  logic                reg_rd_i,
   input  spi_reg_e            reg_addr_i,
   input  logic [`SPI_DW-1:0]  reg_wdata_i,
   input  logic [3:0]          reg_wstrb_i,
   output logic [`SPI_DW-1:0]  reg_rdata_o,
   output logic                reg_err_o,
   output logic                start_o,
   output spi_size_e           size_o,
   output logic [`SPI_DW-1:0]  tx_data_o,
   output logic [7:0]          div_o,
   input  logic                busy_i,
   input  logic                done_i,
   input  logic [`SPI_DW-1:0]  rx_data_i,
   output logic                irq_o
);

   logic [7:0]         div_q;
   logic               done_q;
   spi_size_e          size_q;
   logic [`SPI_DW-1:0] tx_q;
   logic [`SPI_DW-1:0] rx_q;
   spi_size_e          wr_size;
   logic               size_ok;
   logic               wr_err;
   logic               rd_err;

   // strobe pattern gives the transfer size, anything else is refused
   always_comb begin
      wr_size = SZ_BYTE;
      size_ok = 1'b1;
      case (reg_wstrb_i)
         4'b0001: wr_size = SZ_BYTE;
         4'b0011: wr_size = SZ_HALF;
         4'b1111: wr_size = SZ_WORD;
         default: size_ok = 1'b0;
      endcase
   end

   always_comb begin
      wr_err      = 1'b1;
      rd_err      = 1'b0;
      reg_rdata_o = '0;
      case (reg_addr_i)
         REG_CTRL: begin
            wr_err      = 1'b0;
            reg_rdata_o = {{(`SPI_DW-8){1'b0}}, div_q};
         end
         REG_STATUS: reg_rdata_o = {{(`SPI_DW-2){1'b0}}, done_q, busy_i};
         REG_TXDATA: begin
            wr_err      = !size_ok || busy_i;
            reg_rdata_o = tx_q;
         end
         REG_RXDATA: reg_rdata_o = rx_q;
         default:    rd_err = 1'b1;
      endcase
   end

   assign reg_err_o = (reg_wr_i && wr_err) || (reg_rd_i && rd_err);
   assign start_o   = reg_wr_i && !wr_err && (reg_addr_i == REG_TXDATA);

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         div_q  <= `SPI_DIV_RST;
         done_q <= 1'b0;
         size_q <= SZ_BYTE;
      end else begin
         if (reg_wr_i && !wr_err && reg_addr_i == REG_CTRL && reg_wstrb_i[0]) begin
            div_q <= reg_wdata_i[7:0];
         end
         if (start_o) begin
            size_q <= wr_size;
         end
         // a new done wins over a STATUS read in the same cycle
         if (done_i) begin
            done_q <= 1'b1;
         end else if (reg_rd_i && reg_addr_i == REG_STATUS) begin
            done_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (start_o) begin
         tx_q <= reg_wdata_i;
      end
      if (done_i) begin
         rx_q <= rx_data_i;
      end
   end

   assign size_o    = size_q;
   assign tx_data_o = tx_q;
   assign div_o     = div_q;
   assign irq_o     = done_q;

endmodule

// File: src/axi_spi_bridge.sv
`timescale 1ns/1ps
`include "spi_defs.svh"

module axi_spi_bridge
   import spi_pkg::*;
(
   input  logic                s_axi_aclk_i,
   input  logic                s_axi_aresetn_i,
   input  logic [31:0]         s_axi_awaddr_i,
   input  logic                s_axi_awvalid_i,
   output logic                s_axi_awready_o,
   input  logic [`SPI_DW-1:0]  s_axi_wdata_i,
   input  logic [3:0]          s_axi_wstrb_i,
   input  logic                s_axi_wvalid_i,
   output logic                s_axi_wready_o,
   output logic [1:0]          s_axi_bresp_o,
   output logic                s_axi_bvalid_o,
   input  logic                s_axi_bready_i,
   input  logic [31:0]         s_axi_araddr_i,
   input  logic                s_axi_arvalid_i,
   output logic                s_axi_arready_o,
   output logic [`SPI_DW-1:0]  s_axi_rdata_o,
   output logic [1:0]          s_axi_rresp_o,
   output logic                s_axi_rvalid_o,
   input  logic                s_axi_rready_i,
   output logic                reg_wr_o,
   output logic                reg_rd_o,
   output spi_reg_e            reg_addr_o,
   output logic [`SPI_DW-1:0]  reg_wdata_o,
   output logic [3:0]          reg_wstrb_o,
   input  logic [`SPI_DW-1:0]  reg_rdata_i,
   input  logic                reg_err_i
);

   logic               wr_acc;
   logic               rd_acc;
   logic               aw_hit;
   logic               ar_hit;
   logic               bvalid_q;
   logic               rvalid_q;
   axi_resp_e          bresp_q;
   axi_resp_e          rresp_q;
   logic [`SPI_DW-1:0] rdata_q;

   // base compare after masking, offsets above 0x1F are never mapped
   function automatic logic addr_hit(input logic [31:0] addr);
      addr_hit = ((addr & ~`SPI_MASK_ADDR) == `SPI_BASE_ADDR) && (addr[7:5] == 3'd0);
   endfunction

   assign aw_hit = addr_hit(s_axi_awaddr_i);
   assign ar_hit = addr_hit(s_axi_araddr_i);

   // one transaction at a time, a complete write request beats a read
   assign wr_acc = s_axi_awvalid_i && s_axi_wvalid_i && !bvalid_q && !rvalid_q;
   assign rd_acc = s_axi_arvalid_i && !rvalid_q && !bvalid_q
                   && !(s_axi_awvalid_i && s_axi_wvalid_i);

   assign s_axi_awready_o = wr_acc;
   assign s_axi_wready_o  = wr_acc;
   assign s_axi_arready_o = rd_acc;

   // out of window accesses never reach the register file
   assign reg_wr_o    = wr_acc && aw_hit;
   assign reg_rd_o    = rd_acc && ar_hit;
   assign reg_addr_o  = wr_acc ? spi_reg_e'(s_axi_awaddr_i[4:2]) : spi_reg_e'(s_axi_araddr_i[4:2]);
   assign reg_wdata_o = s_axi_wdata_i;
   assign reg_wstrb_o = s_axi_wstrb_i;

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_acc) begin
            bvalid_q <= 1'b1;
         end else if (s_axi_bready_i) begin
            bvalid_q <= 1'b0;
         end
         if (rd_acc) begin
            rvalid_q <= 1'b1;
         end else if (s_axi_rready_i) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   // response payload is captured once and held until accepted
   always_ff @(posedge s_axi_aclk_i) begin
      if (wr_acc) begin
         bresp_q <= (aw_hit && !reg_err_i) ? RESP_OKAY : RESP_SLVERR;
      end
      if (rd_acc) begin
         rresp_q <= (ar_hit && !reg_err_i) ? RESP_OKAY : RESP_SLVERR;
         rdata_q <= (ar_hit && !reg_err_i) ? reg_rdata_i : '0;
      end
   end

   assign s_axi_bvalid_o = bvalid_q;
   assign s_axi_bresp_o  = bresp_q;
   assign s_axi_rvalid_o = rvalid_q;
   assign s_axi_rresp_o  = rresp_q;
   assign s_axi_rdata_o  = rdata_q;

endmodule

// File: src/spi_pkg.sv
package spi_pkg;

   // register offsets, decoded from address bits [4:2]
   typedef enum logic [2:0] {
      REG_CTRL   = 3'd0,
      REG_STATUS = 3'd1,
      REG_TXDATA = 3'd2,
      REG_RXDATA = 3'd3
   } spi_reg_e;

   // transfer size taken from the TXDATA write strobes
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } spi_size_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

endpackage

// File: src/spi_defs.svh
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// window of the SPI block on the AXI bus
`define SPI_BASE_ADDR 32'h2001_0000

// bits cleared before the base compare
`define SPI_MASK_ADDR 32'h0000_00FF

// register data width
`define SPI_DW 32

// half-period divider out of reset
`define SPI_DIV_RST 8'd3

`endif
